// File: dv/backend_tb_table.svh
`ifndef BACKEND_TB_TABLE_SVH
`define BACKEND_TB_TABLE_SVH

// columns: op, rd, rs1, rs2 or imm, expected retire data, issue count as slot 0
task automatic load_table();
    tbl[0]  = make_imm_row(1, 0, 100, 32'h0000_0064, 2);
    tbl[1]  = make_imm_row(2, 0, -7, 32'hffff_fff9, 2);
    tbl[2]  = make_imm_row(3, 1, 25, 32'h0000_007d, 2);
    tbl[3]  = make_imm_row(0, 2, 50, 32'h0000_002b, 2);             // write to x0
    tbl[4]  = make_reg_row(OP_ADD, 4, 0, 3, 32'h0000_007d, 1);      // x0 reads zero
    tbl[5]  = make_reg_row(OP_SUB, 5, 4, 2, 32'h0000_0084, 1);
    tbl[6]  = make_reg_row(OP_AND, 6, 5, 3, 32'h0000_0004, 1);
    tbl[7]  = make_reg_row(OP_OR, 7, 6, 2, 32'hffff_fffd, 1);
    tbl[8]  = make_reg_row(OP_XOR, 8, 7, 1, 32'hffff_ff99, 1);
    tbl[9]  = make_reg_row(OP_SLT, 9, 8, 1, 32'h0000_0001, 2);
    tbl[10] = make_reg_row(OP_SLT, 10, 1, 8, 32'h0000_0000, 2);
    tbl[11] = make_imm_row(11, 0, 9, 32'h0000_0009, 2);
    tbl[12] = make_reg_row(OP_MUL, 12, 3, 5, 32'h0000_4074, 1);     // slot 1 MUL
    tbl[13] = make_reg_row(OP_MUL, 13, 12, 11, 32'h0002_4414, 1);   // MUL pair splits
    tbl[14] = make_reg_row(OP_MUL, 14, 2, 1, 32'hffff_fd44, 2);
    tbl[15] = make_reg_row(OP_ADD, 15, 13, 12, 32'h0002_8488, 1);
    tbl[16] = make_reg_row(OP_SUB, 16, 14, 15, 32'hfffd_78bc, 2);
    tbl[17] = make_imm_row(17, 0, -8192, 32'hffff_e000, 1);         // most negative imm
    for (int i = 0; i < ROWS; i++) begin
        tbl[i].inst.pc = 32'(4 * i);
    end
endtask

`endif

// File: dv/backend_tb.sv
`default_nettype none

module backend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import backend_pkg::*;

    localparam int DATA_WIDTH     = XLEN;
    localparam int REG_COUNT      = NUM_REGS;
    localparam int MUL_CYCLES     = MUL_STEPS;
    localparam int ROWS           = 18;
    localparam int TIMEOUT_CYCLES = ROWS * (MUL_CYCLES + 4) + 50;
    localparam int unsigned SEED  = 32'ha48b_4e63;

    typedef logic [1:0] issue_cnt_t;

    typedef struct packed {
        inst_t             inst;
        logic [REG_AW-1:0] exp_dest;
        logic [XLEN-1:0]   exp_data;
        issue_cnt_t        exp_issue; // as slot 0 with a valid slot 1
    } row_t;

    logic          clk;
    logic          rst;
    inst_t [1:0]   inst;
    logic [1:0]    inst_valid;
    issue_cnt_t    issue_num;
    logic          stall;
    retire_t [1:0] retire;

    row_t tbl [ROWS];
    int   ptr;           // table row sitting in slot 0
    int   ret_idx;       // next row expected to retire
    int   n_take;
    int   stall_cycles;
    int   cycle_cnt = 0;

    backend #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_COUNT  (REG_COUNT),
        .MUL_CYCLES (MUL_CYCLES)
    ) dut0 (
        .clk          (clk),
        .rst_i        (rst),
        .inst_i       (inst),
        .inst_valid_i (inst_valid),
        .issue_num_o  (issue_num),
        .stall_o      (stall),
        .retire_o     (retire)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0d ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp, input int row);
        if (got !== exp) begin
            report_mismatch($sformatf(
                "row %0d retired v %b dest %0d data %h pc_lo %h older %b, want %0d %h %h %b",
                row, got.valid, got.dest, got.data, got.pc_lo, got.older,
                exp.dest, exp.data, exp.pc_lo, exp.older));
        end
    endtask

    task automatic check_issue(input issue_cnt_t got, input issue_cnt_t exp, input int row);
        if (got !== exp) begin
            report_mismatch($sformatf("issue count %0d with row %0d in slot 0, expected %0d",
                                      got, row, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    function automatic row_t make_reg_row(input op_e op, input int rd, input int rs1,
                                          input int rs2, input logic [XLEN-1:0] data,
                                          input int issue);
        row_t row;
        row = '0;
        row.inst.word.r.op  = op;
        row.inst.word.r.rd  = REG_AW'(rd);
        row.inst.word.r.rs1 = REG_AW'(rs1);
        row.inst.word.r.rs2 = REG_AW'(rs2);
        row.exp_dest        = REG_AW'(rd);
        row.exp_data        = data;
        row.exp_issue       = issue_cnt_t'(issue);
        return row;
    endfunction

    function automatic row_t make_imm_row(input int rd, input int rs1, input int imm,
                                          input logic [XLEN-1:0] data, input int issue);
        row_t row;
        row = '0;
        row.inst.word.i.op  = OP_ADDI;
        row.inst.word.i.rd  = REG_AW'(rd);
        row.inst.word.i.rs1 = REG_AW'(rs1);
        row.inst.word.i.imm = 14'(imm);
        row.exp_dest        = REG_AW'(rd);
        row.exp_data        = data;
        row.exp_issue       = issue_cnt_t'(issue);
        return row;
    endfunction

    task automatic drive_slots(input logic idle);
        for (int s = 0; s < 2; s++) begin
            if (!idle && ptr + s < ROWS) begin
                inst[s]       <= tbl[ptr + s].inst;
                inst_valid[s] <= 1'b1;
            end else begin
                inst[s]       <= '0;
                inst_valid[s] <= 1'b0;
            end
        end
    endtask

    task automatic check_next_retire(input retire_t got, input logic first);
        retire_t exp;
        if (ret_idx >= ptr) begin
            $display("retire at %0d ns without an issued instruction to match", $time);
            stop_run();
        end else begin
            exp.valid = 1'b1;
            exp.dest  = tbl[ret_idx].exp_dest;
            exp.data  = tbl[ret_idx].exp_data;
            exp.pc_lo = tbl[ret_idx].inst.pc[PC_LO_W-1:0];
            exp.older = first; // second of a same-cycle pair is the younger one
            check_retire(got, exp, ret_idx);
            ret_idx++;
        end
    endtask

    // program order from the older flag
    task automatic collect_retires();
        if (retire[0].valid && retire[1].valid) begin
            if (retire[1].older) begin
                check_next_retire(retire[1], 1'b1);
                check_next_retire(retire[0], 1'b0);
            end else begin
                check_next_retire(retire[0], 1'b1);
                check_next_retire(retire[1], 1'b0);
            end
        end else if (retire[0].valid) begin
            check_next_retire(retire[0], 1'b1);
        end else if (retire[1].valid) begin
            check_next_retire(retire[1], 1'b1);
        end
    endtask

    task automatic sample_cycle();
        if (stall) begin
            stall_cycles++;
        end
        if (stall && inst_valid[0]) begin
            check_issue(issue_num, 2'd0, ptr); // nothing issues under stall
        end else if (inst_valid == 2'b11) begin
            check_issue(issue_num, tbl[ptr].exp_issue, ptr);
        end
        collect_retires();
        n_take = int'(issue_num);
    endtask

    initial begin
        void'($urandom(SEED));
        load_table();
        rst          = 1'b1;
        inst         = '0;
        inst_valid   = '0;
        ptr          = 0;
        ret_idx      = 0;
        n_take       = 0;
        stall_cycles = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit(stall, 1'b0, "stall after reset");
        check_bit(retire[0].valid | retire[1].valid, 1'b0, "retire valid after reset");
        @(posedge clk);
        drive_slots(1'b0);
        while (ret_idx < ROWS) begin
            @(negedge clk);
            sample_cycle();
            @(posedge clk);
            ptr += n_take;
            drive_slots(n_take != 0 && $urandom % 4 == 0); // random idle cycle
        end
        check_bit(stall_cycles != 0, 1'b1, "stall seen during multiplies");
        if (ptr != ROWS) begin
            $display("only %0d of %0d rows were consumed", ptr, ROWS);
            stop_run();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    `include "backend_tb_table.svh"

endmodule

`default_nettype wire

// File: rtl/backend.sv
`default_nettype none

module backend #(
    parameter int DATA_WIDTH = backend_pkg::XLEN,
    parameter int REG_COUNT  = backend_pkg::NUM_REGS,
    parameter int MUL_CYCLES = backend_pkg::MUL_STEPS
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  backend_pkg::inst_t [1:0]   inst_i,
    input  logic [1:0]                 inst_valid_i,
    output logic [1:0]                 issue_num_o, // 0, 1 or 2
    output logic                       stall_o,
    output backend_pkg::retire_t [1:0] retire_o
);
    import backend_pkg::*;

    localparam int AW = $clog2(REG_COUNT);

    logic [1:0]                 issue;
    logic                       revert; // slot 1 goes to pipe 0
    fwd_sel_e [1:0][1:0]        fwd_sel;
    dest_t [1:0]                ex_dest;
    retire_t [1:0]              ex_res;
    retire_t [1:0]              wb_res;
    retire_t [3:0]              fwd_src;
    logic [1:0]                 busy;
    logic [3:0][AW-1:0]         rf_r_addr;  // two per pipe
    logic [3:0][DATA_WIDTH-1:0] rf_r_data;
    logic [1:0]                 rf_w_en;
    logic [1:0][AW-1:0]         rf_w_addr;
    logic [1:0][DATA_WIDTH-1:0] rf_w_data;

    assign issue_num_o = {issue[1], issue[0] & ~issue[1]};
    assign stall_o     = |busy;
    assign fwd_src     = {wb_res, ex_res};
    assign retire_o    = wb_res;

    issue_ctrl #(
        .REG_COUNT (REG_COUNT)
    ) u_issue_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .stall_i      (stall_o),
        .ex_dest_i    (ex_dest),
        .issue_o      (issue),
        .revert_o     (revert),
        .fwd_sel_o    (fwd_sel)
    );

    reg_file #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_COUNT  (REG_COUNT),
        .READ_PORTS (4)
    ) u_reg_file (
        .clk       (clk),
        .rst_i     (rst_i),
        .w_en_i    (rf_w_en),
        .w_addr_i  (rf_w_addr),
        .w_data_i  (rf_w_data),
        .w_order_i (wb_res[0].older), // pipe 0 older means pipe 1 wins
        .r_addr_i  (rf_r_addr),
        .r_data_o  (rf_r_data)
    );

    for (genvar p = 0; p < 2; p++) begin : g_pipe
        logic     slot; // instruction slot steered here
        pipe_in_t pin;

        assign slot = revert ^ (p == 1);

        always_comb begin
            pin.valid    = issue[slot];
            pin.inst     = inst_i[slot];
            pin.fwd_sel  = fwd_sel[p];
            pin.reg_data = rf_r_data[2*p+1 -: 2];
            pin.older    = !slot;
        end

        assign rf_r_addr[2*p]   = AW'(inst_i[slot].word.r.rs1);
        assign rf_r_addr[2*p+1] = AW'(inst_i[slot].word.r.rs2);

        exec_pipe #(
            .DATA_WIDTH (DATA_WIDTH),
            .MAIN_PIPE  (p == 0),
            .MUL_CYCLES (MUL_CYCLES)
        ) u_exec_pipe (
            .clk       (clk),
            .rst_i     (rst_i),
            .stall_i   (stall_o),
            .pipe_i    (pin),
            .fwd_src_i (fwd_src),
            .ex_o      (ex_res[p]),
            .wb_o      (wb_res[p]),
            .busy_o    (busy[p])
        );

        assign ex_dest[p] = '{valid: ex_res[p].valid, older: ex_res[p].older,
                              idx: ex_res[p].dest};
        assign rf_w_en[p]   = wb_res[p].valid;
        assign rf_w_addr[p] = AW'(wb_res[p].dest);
        assign rf_w_data[p] = wb_res[p].data;
    end

endmodule

`default_nettype wire

// File: rtl/backend_pkg.sv
`default_nettype none

package backend_pkg;

    parameter int XLEN      = 32;
    parameter int NUM_REGS  = 32;
    parameter int MUL_STEPS = 32; // one multiplier bit per step

    localparam int REG_AW  = $clog2(NUM_REGS);
    localparam int PC_LO_W = 4;
    localparam int R_PAD_W = 32 - 4 - 3 * REG_AW;
    localparam int I_PAD_W = 32 - 4 - 2 * REG_AW - 14;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_ADDI = 4'd6,
        OP_MUL  = 4'd7
    } op_e;

    // opcode, rd and rs1 share position in both forms
    typedef union packed {
        struct packed {
            op_e                op;
            logic [REG_AW-1:0]  rd;
            logic [REG_AW-1:0]  rs1;
            logic [REG_AW-1:0]  rs2;
            logic [R_PAD_W-1:0] pad;
        } r;
        struct packed {
            op_e                op;
            logic [REG_AW-1:0]  rd;
            logic [REG_AW-1:0]  rs1;
            logic signed [13:0] imm;
            logic [I_PAD_W-1:0] pad;
        } i;
    } inst_u;

    typedef struct packed {
        inst_u       word;
        logic [31:0] pc;
    } inst_t;

    typedef enum logic [2:0] {
        FWD_REG = 3'd0,
        FWD_EX0 = 3'd1,
        FWD_EX1 = 3'd2,
        FWD_WB0 = 3'd3,
        FWD_WB1 = 3'd4
    } fwd_sel_e;

    typedef struct packed {
        logic                 valid;
        inst_t                inst;
        fwd_sel_e [1:0]       fwd_sel;  // per source operand
        logic [1:0][XLEN-1:0] reg_data;
        logic                 older;    // came from slot 0
    } pipe_in_t;

    typedef struct packed {
        logic               valid;
        logic [REG_AW-1:0]  dest;
        logic [XLEN-1:0]    data;
        logic [PC_LO_W-1:0] pc_lo;
        logic               older;
    } retire_t;

    // producer tag seen by issue control
    typedef struct packed {
        logic              valid;
        logic              older;
        logic [REG_AW-1:0] idx;
    } dest_t;

endpackage

`default_nettype wire

// File: rtl/exec_pipe.sv
`default_nettype none

module exec_pipe #(
    parameter int DATA_WIDTH = backend_pkg::XLEN,
    parameter bit MAIN_PIPE  = 1'b0,
    parameter int MUL_CYCLES = backend_pkg::MUL_STEPS
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      stall_i,
    input  backend_pkg::pipe_in_t     pipe_i,
    input  backend_pkg::retire_t [3:0] fwd_src_i, // ex0, ex1, wb0, wb1
    output backend_pkg::retire_t      ex_o,
    output backend_pkg::retire_t      wb_o,
    output logic                      busy_o
);
    import backend_pkg::*;

    logic [1:0][DATA_WIDTH-1:0] opnd;
    logic [DATA_WIDTH-1:0]      imm_ext;
    logic                       ex_valid_q;
    logic                       ex_older_q;
    inst_t                      ex_inst_q;
    logic [DATA_WIDTH-1:0]      ex_a_q;
    logic [DATA_WIDTH-1:0]      ex_b_q;
    op_e                        ex_op;
    logic [DATA_WIDTH-1:0]      alu_res;
    logic [DATA_WIDTH-1:0]      mul_product;
    logic                       wb_valid_q;
    retire_t                    wb_q;

    always_comb begin
        for (int j = 0; j < 2; j++) begin
            case (pipe_i.fwd_sel[j])
                FWD_EX0: opnd[j] = fwd_src_i[0].data;
                FWD_EX1: opnd[j] = fwd_src_i[1].data;
                FWD_WB0: opnd[j] = fwd_src_i[2].data;
                FWD_WB1: opnd[j] = fwd_src_i[3].data;
                default: opnd[j] = pipe_i.reg_data[j];
            endcase
        end
    end

    assign imm_ext = {{(DATA_WIDTH - 14){pipe_i.inst.word.i.imm[13]}}, pipe_i.inst.word.i.imm};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_q <= 1'b0;
        end else if (!stall_i) begin
            ex_valid_q <= pipe_i.valid;
        end
    end

    // operands are captured here, so a stall keeps them
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_inst_q  <= pipe_i.inst;
            ex_older_q <= pipe_i.older;
            ex_a_q     <= opnd[0];
            ex_b_q     <= (pipe_i.inst.word.r.op == OP_ADDI) ? imm_ext : opnd[1];
        end
    end

    assign ex_op = ex_inst_q.word.r.op;

    always_comb begin
        case (ex_op)
            OP_ADD, OP_ADDI: alu_res = ex_a_q + ex_b_q;
            OP_SUB:          alu_res = ex_a_q - ex_b_q;
            OP_AND:          alu_res = ex_a_q & ex_b_q;
            OP_OR:           alu_res = ex_a_q | ex_b_q;
            OP_XOR:          alu_res = ex_a_q ^ ex_b_q;
            OP_SLT:          alu_res = {{(DATA_WIDTH - 1){1'b0}}, $signed(ex_a_q) < $signed(ex_b_q)};
            OP_MUL:          alu_res = mul_product; // valid once busy drops
            default:         alu_res = '0;
        endcase
    end

    always_comb begin
        ex_o.valid = ex_valid_q;
        ex_o.dest  = ex_inst_q.word.r.rd;
        ex_o.data  = alu_res;
        ex_o.pc_lo = ex_inst_q.pc[PC_LO_W-1:0];
        ex_o.older = ex_older_q;
    end

    always_ff @(posedge clk) begin
        if (rst_i || stall_i) begin
            wb_valid_q <= 1'b0; // bubble while EX waits
        end else begin
            wb_valid_q <= ex_o.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_q <= ex_o;
    end

    always_comb begin
        wb_o       = wb_q;
        wb_o.valid = wb_valid_q;
    end

    if (MAIN_PIPE) begin : g_mul
        logic mul_start;

        assign mul_start = pipe_i.valid && !stall_i && pipe_i.inst.word.r.op == OP_MUL;

        mul_seq #(
            .DATA_WIDTH (DATA_WIDTH),
            .MUL_CYCLES (MUL_CYCLES)
        ) u_mul_seq (
            .clk       (clk),
            .rst_i     (rst_i),
            .start_i   (mul_start),
            .a_i       (opnd[0]),
            .b_i       (opnd[1]),
            .busy_o    (busy_o),
            .product_o (mul_product)
        );
    end else begin : g_no_mul
        assign busy_o      = 1'b0;
        assign mul_product = '0;

        // steering in issue control keeps MUL off this pipe
        a_no_mul: assert property (@(posedge clk) disable iff (rst_i)
            ex_valid_q |-> ex_op != OP_MUL)
            else $error("MUL reached the secondary pipe");
    end

endmodule

`default_nettype wire

// File: rtl/issue_ctrl.sv
`default_nettype none

module issue_ctrl #(
    parameter int REG_COUNT = backend_pkg::NUM_REGS
) (
    input  logic                             clk,
    input  logic                             rst_i,
    input  backend_pkg::inst_t [1:0]         inst_i,
    input  logic [1:0]                       inst_valid_i,
    input  logic                             stall_i,
    input  backend_pkg::dest_t [1:0]         ex_dest_i,
    output logic [1:0]                       issue_o,
    output logic                             revert_o,
    output backend_pkg::fwd_sel_e [1:0][1:0] fwd_sel_o
);
    import backend_pkg::*;

    localparam int AW = $clog2(REG_COUNT);

    dest_t [1:0]             wb_dest_q;  // tracks WB of both pipes
    fwd_sel_e [1:0][1:0]     slot_sel;   // by slot, then operand
    logic [1:0][1:0][AW-1:0] src;
    logic [1:0]              uses_rs2;
    logic [AW-1:0]           rd0;
    logic                    raw_hazard;
    logic                    dual_mul;

    // youngest producer wins, EX before WB
    function automatic fwd_sel_e pick_src(input logic [AW-1:0] idx, input logic used,
                                          input dest_t [1:0] ex, input dest_t [1:0] wb);
        logic [1:0] ex_hit;
        logic [1:0] wb_hit;
        for (int p = 0; p < 2; p++) begin
            ex_hit[p] = used && idx != '0 && ex[p].valid && AW'(ex[p].idx) == idx;
            wb_hit[p] = used && idx != '0 && wb[p].valid && AW'(wb[p].idx) == idx;
        end
        if (ex_hit == 2'b11) return ex[0].older ? FWD_EX1 : FWD_EX0;
        if (ex_hit[0]) return FWD_EX0;
        if (ex_hit[1]) return FWD_EX1;
        if (wb_hit == 2'b11) return wb[0].older ? FWD_WB1 : FWD_WB0;
        if (wb_hit[0]) return FWD_WB0;
        if (wb_hit[1]) return FWD_WB1;
        return FWD_REG;
    endfunction

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src[s][0]   = AW'(inst_i[s].word.r.rs1);
            src[s][1]   = AW'(inst_i[s].word.r.rs2);
            uses_rs2[s] = inst_i[s].word.r.op != OP_ADDI; // imm bits overlap rs2
        end
    end

    assign rd0        = AW'(inst_i[0].word.r.rd);
    assign raw_hazard = rd0 != '0 && (src[1][0] == rd0 || (uses_rs2[1] && src[1][1] == rd0));
    assign dual_mul   = inst_i[0].word.r.op == OP_MUL && inst_i[1].word.r.op == OP_MUL;

    assign issue_o[0] = inst_valid_i[0] && !stall_i;
    assign issue_o[1] = inst_valid_i[1] && !stall_i && !raw_hazard && !dual_mul; // source fills slot 0 first
    // slot 0 cannot be MUL here, dual_mul already split the pair
    assign revert_o   = issue_o[1] && inst_i[1].word.r.op == OP_MUL;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            slot_sel[s][0] = pick_src(src[s][0], 1'b1, ex_dest_i, wb_dest_q);
            slot_sel[s][1] = pick_src(src[s][1], uses_rs2[s], ex_dest_i, wb_dest_q);
        end
        for (int p = 0; p < 2; p++) begin
            fwd_sel_o[p] = slot_sel[p ^ revert_o];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || stall_i) begin
            wb_dest_q <= '0; // pipes push bubbles into WB on stall
        end else begin
            wb_dest_q <= ex_dest_i;
        end
    end

    a_in_order: assert property (@(posedge clk) disable iff (rst_i) issue_o[1] |-> issue_o[0])
        else $error("slot 1 issued without slot 0");

endmodule

`default_nettype wire

// File: rtl/mul_seq.sv
`default_nettype none

module mul_seq #(
    parameter int DATA_WIDTH = backend_pkg::XLEN,
    parameter int MUL_CYCLES = backend_pkg::MUL_STEPS
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  logic [DATA_WIDTH-1:0] a_i,
    input  logic [DATA_WIDTH-1:0] b_i,
    output logic                  busy_o,
    output logic [DATA_WIDTH-1:0] product_o
);

    localparam int CW = $clog2(MUL_CYCLES + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_e;

    state_e                state_q;
    logic [CW-1:0]         steps_q; // steps left in this multiply
    logic [DATA_WIDTH-1:0] mcand_q;
    logic [DATA_WIDTH-1:0] mplier_q;
    logic [DATA_WIDTH-1:0] acc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            steps_q <= '0;
        end else begin
            case (state_q)
                S_RUN: begin
                    steps_q <= steps_q - 1'b1;
                    if (steps_q == CW'(1)) begin
                        state_q <= S_DONE;
                    end
                end
                default: begin // a new multiply can follow straight out of done
                    if (start_i) begin
                        state_q <= S_RUN;
                        steps_q <= CW'(MUL_CYCLES);
                    end else begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_RUN) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end else if (start_i) begin
            mcand_q  <= a_i;
            mplier_q <= b_i;
            acc_q    <= '0;
        end
    end

    assign busy_o    = state_q == S_RUN;
    assign product_o = acc_q; // low half only

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst_i) start_i |-> !busy_o)
        else $error("multiply started while busy");

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int DATA_WIDTH = backend_pkg::XLEN,
    parameter int REG_COUNT  = backend_pkg::NUM_REGS,
    parameter int READ_PORTS = 4,
    localparam int AW        = $clog2(REG_COUNT)
) (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic [1:0]                           w_en_i,
    input  logic [1:0][AW-1:0]                   w_addr_i,
    input  logic [1:0][DATA_WIDTH-1:0]           w_data_i,
    input  logic                                 w_order_i, // set when port 1 is younger
    input  logic [READ_PORTS-1:0][AW-1:0]        r_addr_i,
    output logic [READ_PORTS-1:0][DATA_WIDTH-1:0] r_data_o
);

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];
    logic [1:0]            w_eff;

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            w_eff[p] = w_en_i[p] && w_addr_i[p] != '0;
        end
    end

    // older port first so the younger write lands last
    always_ff @(posedge clk) begin
        if (rst_i) begin
            regs[0] <= '0; // x0 holds zero from here on
        end else begin
            if (w_eff[!w_order_i]) begin
                regs[w_addr_i[!w_order_i]] <= w_data_i[!w_order_i];
            end
            if (w_eff[w_order_i]) begin
                regs[w_addr_i[w_order_i]] <= w_data_i[w_order_i];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            r_data_o[r] = regs[r_addr_i[r]];
        end
    end

    a_no_zero_write: assert property (@(posedge clk) disable iff (rst_i) regs[0] == '0)
        else $error("register 0 was overwritten");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module backend_tb -f tb.f -o sim_backend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_backend)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb.f
+incdir+dv
rtl/backend_pkg.sv
rtl/issue_ctrl.sv
rtl/reg_file.sv
rtl/mul_seq.sv
rtl/exec_pipe.sv
rtl/backend.sv
dv/backend_tb.sv
